// File: Bender.yml
package:
  name: multipu

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/pi1_pkg.sv
      - pu/pu_ctrl.sv
      - pu/pu_addr_counter.sv
      - pu/pu_datapath.sv
      - pu/pu.sv
      - hdl/pi1_arbiter.sv
      - hdl/multipu.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/tb_clkgen.sv
      - bench/multipu_assertions.sv
      - bench/multipu_tb.sv

// File: bench/multipu_assertions.sv
// Handshake and grant properties of the cluster, bound into multipu by the testbench.
`include "multipu_config.svh"

module multipu_assertions #(
	parameter int PUCOUNT = `MULTIPU_PUCOUNT
) (
	input logic                            clk_i,
	input logic                            rst_n_i,
	input pi1_pkg::pi1_op_t                op_i,
	input logic [`MULTIPU_ADDRBITSZ-1:0]   addr_i,
	input logic [`MULTIPU_ARCHBITSZ-1:0]   data_i,
	input logic [`MULTIPU_ARCHBITSZ/8-1:0] sel_i,
	input logic                            rdy_i,
	input logic [PUCOUNT-1:0]              gnt_i,
	input pi1_pkg::pi1_op_t                m_op_i [PUCOUNT],
	input logic [PUCOUNT-1:0]              m_rdy_i
);

	import pi1_pkg::*;

	int                 fails = 0;
	logic [PUCOUNT-1:0] m_req;

	always_comb begin
		for (int i = 0; i < PUCOUNT; i++)
			m_req[i] = (m_op_i[i] != PI1_NOOP);
	end

	a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot(gnt_i))
		else begin
			$error("arbiter grant is not one-hot");
			fails++;
		end

	// A pending slave request may not change until the slave answers.
	a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(op_i != PI1_NOOP && !rdy_i) |=> ($stable(op_i) && $stable(addr_i)
		&& $stable(data_i) && $stable(sel_i)))
		else begin
			$error("slave request changed before rdy");
			fails++;
		end

	// Only the granted master with a request out may see rdy.
	a_rdy_granted: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(m_rdy_i & ~(gnt_i & m_req)) == '0)
		else begin
			$error("rdy returned to a master without the grant or a request");
			fails++;
		end

endmodule

// File: bench/multipu_tb.sv
// Testbench of the checksum cluster with a memory slave, random rdy delays and a job model.
// Top module is multipu_tb. Compile it with files.f.
`include "multipu_config.svh"

module multipu_tb;

	import pi1_pkg::*;

	localparam int PUCOUNT    = 2;
	localparam int MAXW       = `MULTIPU_MAXWORDS;
	localparam int MEMWORDS   = 128;
	localparam int BASE0      = 16;
	localparam int BASE1      = 64;
	localparam int NJOBS      = 14;
	localparam int HALT_LIMIT = PUCOUNT * (MAXW + 2) * 5 * 2;
	localparam int WATCHDOG   = (NJOBS * PUCOUNT * (MAXW + 2) * 5 + 40) * 10;
	localparam int JOB_ZERO   = 0;
	localparam int JOB_NOZERO = 1;
	localparam int JOB_ANY    = 2;
	localparam logic [31:0] ID_BASE = 32'hC0DE_0100;

	logic                            clk;
	logic                            rst_n;
	pi1_op_t                         op;
	logic [`MULTIPU_ADDRBITSZ-1:0]   addr;
	logic [`MULTIPU_ARCHBITSZ-1:0]   wdata;
	logic [`MULTIPU_ARCHBITSZ/8-1:0] sel;
	logic [`MULTIPU_ARCHBITSZ-1:0]   rdata;
	logic                            rdy;
	logic [PUCOUNT-1:0]              intrqst;
	logic [PUCOUNT-1:0]              intrdy;
	logic [PUCOUNT-1:0]              halted;

	logic [31:0] mem [MEMWORDS];
	logic [31:0] job [PUCOUNT][MAXW];
	int          exp_k [PUCOUNT];
	int          wr_count [PUCOUNT];
	int unsigned delay_tab [1024];
	int          dly_idx;
	logic        busy;
	int          wait_cnt;
	int          last_u;
	logic        last_others;
	int          completions;
	int          errors;
	int          fair_errors;
	int          err_mark;
	int          tests_run;
	int          tests_failed;

	tb_clkgen #(.PERIOD(10), .RST_CYCLES(8)) u_clkgen (.clk_o(clk), .rst_n_o(rst_n));

	multipu #(.PUCOUNT(PUCOUNT)) u_multipu (
		.clk_i      (clk),
		.rst_n_i    (rst_n),
		.pi1_op_o   (op),
		.pi1_addr_o (addr),
		.pi1_data_o (wdata),
		.pi1_sel_o  (sel),
		.pi1_data_i (rdata),
		.pi1_rdy_i  (rdy),
		.intrqst_i  (intrqst),
		.intrdy_o   (intrdy),
		.halted_o   (halted),
		.rstaddr_i  (30'(BASE0)),
		.rstaddr2_i (30'(BASE1)),
		.id_i       (ID_BASE)
	);

	bind multipu multipu_assertions #(.PUCOUNT(PUCOUNT)) u_assertions (
		.clk_i (clk_i), .rst_n_i (rst_n_i), .op_i (pi1_op_o), .addr_i (pi1_addr_o),
		.data_i (pi1_data_o), .sel_i (pi1_sel_o), .rdy_i (pi1_rdy_i),
		.gnt_i (u_arbiter.gnt_q), .m_op_i (m_op), .m_rdy_i (m_rdy)
	);

	function automatic int base_of(input int u);
		return (u == 0) ? BASE0 : BASE1;
	endfunction

	function automatic logic [31:0] fill_word(input int a);
		return {2'b10, 30'(a)} ^ 32'h5A5A_5A5A;
	endfunction

	// A unit's region holds its job words and the two slots after a full-length job.
	function automatic int unit_of(input logic [`MULTIPU_ADDRBITSZ-1:0] a);
		for (int u = 0; u < PUCOUNT; u++)
			if (a >= base_of(u) && a <= base_of(u) + MAXW + 1)
				return u;
		return -1;
	endfunction

	function automatic int job_len(input int u);
		for (int i = 0; i < MAXW; i++)
			if (job[u][i] == '0)
				return i + 1; // The terminator is counted.
		return MAXW;
	endfunction

	function automatic logic [31:0] job_sum(input int u);
		logic [31:0] s;
		s = '0;
		for (int i = 0; i < job_len(u); i++)
			s += job[u][i];
		return s;
	endfunction

	task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic load_job(input int u, input int mode);
		int          zpos;
		logic [31:0] w;
		zpos = int'($urandom % MAXW);
		if (mode == JOB_NOZERO || (mode == JOB_ANY && $urandom % 2 == 1))
			zpos = -1;
		for (int i = 0; i < MAXW; i++) begin
			w = $urandom;
			if (w == '0)
				w = 32'h1;
			job[u][i] = (i == zpos) ? '0 : w;
			mem[base_of(u) + i] = job[u][i];
		end
		for (int i = MAXW; i < MAXW + 2; i++)
			mem[base_of(u) + i] = fill_word(base_of(u) + i);
		exp_k[u] = job_len(u);
		wr_count[u] = 0;
	endtask

	task automatic check_record(input int u);
		int k;
		k = exp_k[u];
		check_val($sformatf("unit %0d id word", u), mem[base_of(u) + k], ID_BASE + u);
		check_val($sformatf("unit %0d sum word", u), mem[base_of(u) + k + 1], job_sum(u));
		check_val($sformatf("unit %0d halted", u), halted[u], 1);
		check_val($sformatf("unit %0d intrdy", u), intrdy[u], 1);
	endtask

	task automatic restart(input logic [PUCOUNT-1:0] mask);
		@(posedge clk);
		intrqst <= mask;
		@(posedge clk);
		intrqst <= '0;
		@(negedge clk);
		for (int u = 0; u < PUCOUNT; u++)
			if (mask[u])
				check_val($sformatf("unit %0d halted after request", u), halted[u], 0);
	endtask

	task automatic wait_halted(input logic [PUCOUNT-1:0] mask);
		int n;
		n = 0;
		@(negedge clk);
		while ((halted & mask) != mask && n < HALT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if ((halted & mask) != mask) begin
			$display("units %b did not halt within %0d cycles", mask, HALT_LIMIT);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == err_mark) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - err_mark);
			tests_failed++;
		end
		err_mark = errors;
	endtask

	task automatic record_write(input int u);
		if (addr != base_of(u) + exp_k[u] && addr != base_of(u) + exp_k[u] + 1) begin
			$display("unit %0d wrote outside its record slots at %0t, address %h", u, $time, addr);
			errors++;
		end
		mem[addr] = wdata;
		wr_count[u]++;
	endtask

	task automatic track_fairness(input int u);
		logic [PUCOUNT-1:0] others;
		others = ~halted & ~(PUCOUNT'(1) << u);
		if (completions > 0 && u == last_u && last_others) begin
			$display("unit %0d completed two transfers in a row at %0t",
				u, $time);
			$display("while another unit still had work left");
			fair_errors++;
		end
		last_u = u;
		last_others = |others;
		completions++;
	endtask

	// Memory slave; a request seen at an edge is answered after its drawn delay.
	always @(posedge clk) begin
		int u;
		if (rdy) begin
			u = unit_of(addr);
			rdy <= 1'b0;
			busy = 1'b0;
			if (u < 0) begin
				$display("transfer at %0t to address %h outside both job regions", $time, addr);
				errors++;
			end else begin
				check_val("slave byte select all ones", &sel, 1);
				if (op == PI1_WROP)
					record_write(u);
				track_fairness(u);
			end
		end else begin
			if (!busy && op != PI1_NOOP) begin
				busy = 1'b1;
				wait_cnt = delay_tab[dly_idx % 1024];
				dly_idx++;
			end
			if (busy) begin
				if (wait_cnt == 0) begin
					rdy   <= 1'b1;
					rdata <= mem[addr];
				end else begin
					wait_cnt--;
				end
			end
		end
	end

	initial begin
		#(WATCHDOG);
		$display("watchdog expired, the tests did not finish in time");
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		void'($urandom(25));
		intrqst = '0;
		rdy = 1'b0;
		rdata = '0;
		busy = 1'b0;
		wait_cnt = 0;
		dly_idx = 0;
		last_u = -1;
		last_others = 1'b0;
		completions = 0;
		errors = 0;
		fair_errors = 0;
		err_mark = 0;
		tests_run = 0;
		tests_failed = 0;
		for (int a = 0; a < MEMWORDS; a++)
			mem[a] = fill_word(a);
		// Every fourth block of 32 is a zero-wait burst.
		for (int i = 0; i < 1024; i++)
			delay_tab[i] = (((i >> 5) & 3) == 1) ? 0 : $urandom % 4;
		load_job(0, JOB_ZERO);
		load_job(1, JOB_ZERO);
		@(posedge rst_n);

		wait_halted('1);
		check_record(0);
		check_record(1);
		end_test("zero_terminated");

		load_job(0, JOB_NOZERO);
		load_job(1, JOB_ZERO);
		restart('1);
		wait_halted('1);
		check_record(0);
		check_record(1);
		end_test("length_limit");

		repeat (4) begin
			load_job(0, JOB_ANY);
			load_job(1, JOB_ANY);
			restart('1);
			wait_halted('1);
			check_record(0);
			check_record(1);
		end
		end_test("random_delays");

		load_job(1, JOB_ANY);
		check_val("unit 1 intrdy", intrdy[1], 1);
		restart(2'b10);
		wait_halted(2'b10);
		check_record(1);
		end_test("restart");

		load_job(0, JOB_NOZERO);
		restart(2'b01);
		repeat (3) @(posedge clk);
		restart(2'b01);
		wait_halted(2'b01);
		check_record(0);
		repeat (20) @(negedge clk);
		check_val("unit 0 halted after idle", halted[0], 1);
		check_val("unit 0 record writes", wr_count[0], 2);
		end_test("request_while_running");

		check_val("transfers seen", completions > 0, 1);
		errors += fair_errors;
		end_test("round_robin");

		errors += u_multipu.u_assertions.fails;
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: bench/tb_clkgen.sv
// Clock and reset source for the cluster testbench.
module tb_clkgen #(
	parameter int PERIOD     = 10,
	parameter int RST_CYCLES = 8
) (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD / 2) clk_o = ~clk_o;
	end

	initial begin
		rst_n_o = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_o);
		rst_n_o <= 1'b1; // Released on a rising edge like any other input.
	end

endmodule

// File: common/multipu_config.svh
// Build-time sizes for the multi-unit checksum cluster.
// Include wherever bus widths, unit count or job length are needed.
`ifndef MULTIPU_CONFIG_SVH
`define MULTIPU_CONFIG_SVH

// Data word width of the pi1 bus.
`define MULTIPU_ARCHBITSZ 32

// Word address width, ARCHBITSZ minus the byte offset bits.
`define MULTIPU_ADDRBITSZ 30

// Default number of checksum units behind the arbiter.
`define MULTIPU_PUCOUNT 2

// Longest job a unit reads before it stops on its own.
`define MULTIPU_MAXWORDS 16

`endif

// File: common/pi1_pkg.sv
// Types shared by the pi1 bus ports and the checksum unit controller.
package pi1_pkg;

	// pi1 bus operation, same encoding on master and slave ports.
	typedef enum logic [1:0] {
		PI1_NOOP = 2'b00,
		PI1_WROP = 2'b01,
		PI1_RDOP = 2'b10,
		PI1_RWOP = 2'b11
	} pi1_op_t;

	// Checksum unit controller states.
	typedef enum logic [1:0] {
		PU_FETCH = 2'b00, // Reading job words.
		PU_WRID  = 2'b01, // Writing the id word of the record.
		PU_WRSUM = 2'b10, // Writing the sum word of the record.
		PU_HALT  = 2'b11  // Done, waiting for an interrupt request.
	} pu_state_t;

endpackage

// File: files.f
+incdir+common
common/pi1_pkg.sv
pu/pu_ctrl.sv
pu/pu_addr_counter.sv
pu/pu_datapath.sv
pu/pu.sv
hdl/pi1_arbiter.sv
hdl/multipu.sv
bench/tb_clkgen.sv
bench/multipu_assertions.sv
bench/multipu_tb.sv

// File: hdl/multipu.sv
// Cluster top: PUCOUNT checksum units sharing one pi1 slave port.
// Unit i reports id_i plus i; unit 0 starts at rstaddr_i, the rest at rstaddr2_i.
`include "multipu_config.svh"

module multipu #(
	parameter int PUCOUNT = `MULTIPU_PUCOUNT
) (
	input  logic                            clk_i,
	input  logic                            rst_n_i,
	output pi1_pkg::pi1_op_t                pi1_op_o,
	output logic [`MULTIPU_ADDRBITSZ-1:0]   pi1_addr_o,
	output logic [`MULTIPU_ARCHBITSZ-1:0]   pi1_data_o,
	output logic [`MULTIPU_ARCHBITSZ/8-1:0] pi1_sel_o,
	input  logic [`MULTIPU_ARCHBITSZ-1:0]   pi1_data_i,
	input  logic                            pi1_rdy_i,
	input  logic [PUCOUNT-1:0]              intrqst_i,
	output logic [PUCOUNT-1:0]              intrdy_o,
	output logic [PUCOUNT-1:0]              halted_o,
	input  logic [`MULTIPU_ADDRBITSZ-1:0]   rstaddr_i,
	input  logic [`MULTIPU_ADDRBITSZ-1:0]   rstaddr2_i,
	input  logic [`MULTIPU_ARCHBITSZ-1:0]   id_i
);

	import pi1_pkg::*;

	pi1_op_t                         m_op    [PUCOUNT];
	logic [`MULTIPU_ADDRBITSZ-1:0]   m_addr  [PUCOUNT];
	logic [`MULTIPU_ARCHBITSZ-1:0]   m_wdata [PUCOUNT];
	logic [`MULTIPU_ARCHBITSZ/8-1:0] m_sel   [PUCOUNT];
	logic [`MULTIPU_ARCHBITSZ-1:0]   m_rdata [PUCOUNT];
	logic [PUCOUNT-1:0]              m_rdy;

	pi1_arbiter #(
		.MASTERCOUNT (PUCOUNT)
	) u_arbiter (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.m_op_i   (m_op),
		.m_addr_i (m_addr),
		.m_data_i (m_wdata),
		.m_sel_i  (m_sel),
		.m_data_o (m_rdata),
		.m_rdy_o  (m_rdy),
		.s_op_o   (pi1_op_o),
		.s_addr_o (pi1_addr_o),
		.s_data_o (pi1_data_o),
		.s_sel_o  (pi1_sel_o),
		.s_data_i (pi1_data_i),
		.s_rdy_i  (pi1_rdy_i)
	);

	for (genvar i = 0; i < PUCOUNT; i++) begin : gen_pu
		pu u_pu (
			.clk_i      (clk_i),
			.rst_n_i    (rst_n_i),
			.pi1_op_o   (m_op[i]),
			.pi1_addr_o (m_addr[i]),
			.pi1_data_o (m_wdata[i]),
			.pi1_sel_o  (m_sel[i]),
			.pi1_data_i (m_rdata[i]),
			.pi1_rdy_i  (m_rdy[i]),
			.intrqst_i  (intrqst_i[i]),
			.intrdy_o   (intrdy_o[i]),
			.halted_o   (halted_o[i]),
			.rstaddr_i  ((i == 0) ? rstaddr_i : rstaddr2_i),
			.id_i       (id_i + `MULTIPU_ARCHBITSZ'(i))
		);
	end

endmodule

// File: hdl/pi1_arbiter.sv
// Round-robin merge of several pi1 masters onto one pi1 slave port.
// The granted request goes straight through; only the grant itself is registered.
`include "multipu_config.svh"

module pi1_arbiter #(
	parameter int MASTERCOUNT = `MULTIPU_PUCOUNT
) (
	input  logic                            clk_i,
	input  logic                            rst_n_i,
	input  pi1_pkg::pi1_op_t                m_op_i   [MASTERCOUNT],
	input  logic [`MULTIPU_ADDRBITSZ-1:0]   m_addr_i [MASTERCOUNT],
	input  logic [`MULTIPU_ARCHBITSZ-1:0]   m_data_i [MASTERCOUNT],
	input  logic [`MULTIPU_ARCHBITSZ/8-1:0] m_sel_i  [MASTERCOUNT],
	output logic [`MULTIPU_ARCHBITSZ-1:0]   m_data_o [MASTERCOUNT],
	output logic [MASTERCOUNT-1:0]          m_rdy_o,
	output pi1_pkg::pi1_op_t                s_op_o,
	output logic [`MULTIPU_ADDRBITSZ-1:0]   s_addr_o,
	output logic [`MULTIPU_ARCHBITSZ-1:0]   s_data_o,
	output logic [`MULTIPU_ARCHBITSZ/8-1:0] s_sel_o,
	input  logic [`MULTIPU_ARCHBITSZ-1:0]   s_data_i,
	input  logic                            s_rdy_i
);

	import pi1_pkg::*;

	localparam int IDXW = (MASTERCOUNT > 1) ? $clog2(MASTERCOUNT) : 1;

	logic [MASTERCOUNT-1:0] gnt_q;
	logic [MASTERCOUNT-1:0] gnt_d;
	logic [IDXW-1:0]        gnt_idx;
	logic [IDXW-1:0]        nxt_idx;
	logic                   move;

	always_comb begin
		gnt_idx = '0;
		for (int i = 0; i < MASTERCOUNT; i++) begin
			if (gnt_q[i])
				gnt_idx = IDXW'(i);
		end
	end

	// First requester after the current one; wraps back to the current one last.
	always_comb begin
		int  cand;
		logic found;
		nxt_idx = gnt_idx;
		found   = 1'b0;
		for (int off = 1; off <= MASTERCOUNT; off++) begin
			cand = (int'(gnt_idx) + off) % MASTERCOUNT;
			if (!found && m_op_i[cand] != PI1_NOOP) begin
				nxt_idx = IDXW'(cand);
				found   = 1'b1;
			end
		end
	end

	assign move  = (s_op_o == PI1_NOOP) || s_rdy_i; // Nothing left pending on the slave.
	assign gnt_d = MASTERCOUNT'(1) << nxt_idx;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			gnt_q <= MASTERCOUNT'(1);
		else if (move)
			gnt_q <= gnt_d;
	end

	assign s_op_o   = m_op_i[gnt_idx];
	assign s_addr_o = m_addr_i[gnt_idx];
	assign s_data_o = m_data_i[gnt_idx];
	assign s_sel_o  = m_sel_i[gnt_idx];

	always_comb begin
		for (int i = 0; i < MASTERCOUNT; i++) begin
			m_rdy_o[i]  = gnt_q[i] & s_rdy_i;
			m_data_o[i] = gnt_q[i] ? s_data_i : '0;
		end
	end

endmodule

// File: pu/pu.sv
// One checksum unit on a pi1 master port.
// Reads a job from rstaddr_i, then writes its id and sum after the last word.
`include "multipu_config.svh"

module pu (
	input  logic                            clk_i,
	input  logic                            rst_n_i,
	output pi1_pkg::pi1_op_t                pi1_op_o,
	output logic [`MULTIPU_ADDRBITSZ-1:0]   pi1_addr_o,
	output logic [`MULTIPU_ARCHBITSZ-1:0]   pi1_data_o,
	output logic [`MULTIPU_ARCHBITSZ/8-1:0] pi1_sel_o,
	input  logic [`MULTIPU_ARCHBITSZ-1:0]   pi1_data_i,
	input  logic                            pi1_rdy_i,
	input  logic                            intrqst_i,
	output logic                            intrdy_o,
	output logic                            halted_o,
	input  logic [`MULTIPU_ADDRBITSZ-1:0]   rstaddr_i,
	input  logic [`MULTIPU_ARCHBITSZ-1:0]   id_i
);

	logic addr_sel;
	logic clear;
	logic advance;
	logic data_sel;
	logic zero;
	logic limit;
	logic halted;

	pu_ctrl u_ctrl (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.rdy_i      (pi1_rdy_i),
		.zero_i     (zero),
		.limit_i    (limit),
		.intrqst_i  (intrqst_i),
		.op_o       (pi1_op_o),
		.addr_sel_o (addr_sel),
		.clear_o    (clear),
		.advance_o  (advance),
		.data_sel_o (data_sel),
		.halted_o   (halted)
	);

	pu_addr_counter u_addr_counter (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.rstaddr_i  (rstaddr_i),
		.clear_i    (clear),
		.advance_i  (advance),
		.addr_sel_i (addr_sel),
		.addr_o     (pi1_addr_o),
		.limit_o    (limit)
	);

	pu_datapath u_datapath (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.clear_i    (clear),
		.advance_i  (advance),
		.data_i     (pi1_data_i),
		.id_i       (id_i),
		.data_sel_i (data_sel),
		.zero_o     (zero),
		.data_o     (pi1_data_o)
	);

	assign pi1_sel_o = '1; // Whole words only.
	assign halted_o  = halted;
	assign intrdy_o  = halted; // An interrupt is only taken while halted.

endmodule

// File: pu/pu_addr_counter.sv
// Word counter and address generator of one checksum unit.
// Fetch and id addresses are base plus count; the sum slot is one further.
`include "multipu_config.svh"

module pu_addr_counter (
	input  logic                          clk_i,
	input  logic                          rst_n_i,
	input  logic [`MULTIPU_ADDRBITSZ-1:0] rstaddr_i,
	input  logic                          clear_i,
	input  logic                          advance_i,
	input  logic                          addr_sel_i,
	output logic [`MULTIPU_ADDRBITSZ-1:0] addr_o,
	output logic                          limit_o
);

	localparam int CNTW = $clog2(`MULTIPU_MAXWORDS + 1);

	logic [CNTW-1:0] cnt_q;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			cnt_q <= '0;
		else if (clear_i)
			cnt_q <= '0;
		else if (advance_i)
			cnt_q <= cnt_q + 1'b1;
	end

	// High while the word being fetched is the last one a job may read.
	assign limit_o = (cnt_q == CNTW'(`MULTIPU_MAXWORDS - 1));

	assign addr_o = rstaddr_i + `MULTIPU_ADDRBITSZ'(cnt_q)
		+ `MULTIPU_ADDRBITSZ'(addr_sel_i);

endmodule

// File: pu/pu_ctrl.sv
// Sequencer of one checksum unit: fetch words, write the record, halt.
// Every state step waits for rdy on the unit's pi1 master port.
module pu_ctrl (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              rdy_i,
	input  logic              zero_i,
	input  logic              limit_i,
	input  logic              intrqst_i,
	output pi1_pkg::pi1_op_t  op_o,
	output logic              addr_sel_o,
	output logic              clear_o,
	output logic              advance_o,
	output logic              data_sel_o,
	output logic              halted_o
);

	import pi1_pkg::*;

	pu_state_t state_q;
	pu_state_t state_d;
	pi1_op_t   op_q;
	pi1_op_t   op_d;
	logic      xfer_done;

	// A transfer only counts while a request is actually out.
	assign xfer_done = rdy_i && (op_q != PI1_NOOP);

	always_comb begin
		state_d   = state_q;
		advance_o = 1'b0;
		clear_o   = 1'b0;
		case (state_q)
			PU_FETCH: begin
				if (xfer_done) begin
					advance_o = 1'b1; // Count the word and add it to the sum.
					if (zero_i || limit_i)
						state_d = PU_WRID;
				end
			end
			PU_WRID: begin
				if (xfer_done)
					state_d = PU_WRSUM;
			end
			PU_WRSUM: begin
				if (xfer_done)
					state_d = PU_HALT;
			end
			PU_HALT: begin
				if (intrqst_i) begin
					clear_o = 1'b1; // Restart from the reset address.
					state_d = PU_FETCH;
				end
			end
		endcase
	end

	// The op is registered from the next state so it leaves reset as a no-op.
	always_comb begin
		case (state_d)
			PU_FETCH: op_d = PI1_RDOP;
			PU_WRID, PU_WRSUM: op_d = PI1_WROP;
			default: op_d = PI1_NOOP;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= PU_FETCH;
			op_q    <= PI1_NOOP;
		end else begin
			state_q <= state_d;
			op_q    <= op_d;
		end
	end

	assign op_o       = op_q;
	assign addr_sel_o = (state_q == PU_WRSUM); // Sum goes one slot past the id.
	assign data_sel_o = (state_q == PU_WRSUM);
	assign halted_o   = (state_q == PU_HALT);

endmodule

// File: pu/pu_datapath.sv
// Checksum datapath: running sum, zero-word check and write-data select.
`include "multipu_config.svh"

module pu_datapath (
	input  logic                          clk_i,
	input  logic                          rst_n_i,
	input  logic                          clear_i,
	input  logic                          advance_i,
	input  logic [`MULTIPU_ARCHBITSZ-1:0] data_i,
	input  logic [`MULTIPU_ARCHBITSZ-1:0] id_i,
	input  logic                          data_sel_i,
	output logic                          zero_o,
	output logic [`MULTIPU_ARCHBITSZ-1:0] data_o
);

	logic [`MULTIPU_ARCHBITSZ-1:0] sum_q;

	// Wrap-around total of every word read, terminator included.
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			sum_q <= '0;
		else if (clear_i)
			sum_q <= '0;
		else if (advance_i)
			sum_q <= sum_q + data_i;
	end

	assign zero_o = (data_i == '0); // Valid in the cycle rdy returns read data.

	assign data_o = data_sel_i ? sum_q : id_i;

endmodule
